/* filelist.f */
+incdir+include
design/mcu_mem_pkg.sv
design/ahb_addr_stage.sv
design/dual_port_sram.sv
design/ahb_resp_stage.sv
design/renas_memory.sv
bench/renas_memory_asserts.sv
bench/renas_memory_tb.sv

/* Makefile */
# Verilator build and run for the renas_memory testbench
TOP       ?= renas_memory_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= Test FAILED
PASS_MSG  ?= Test OK

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended early, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/renas_memory_tb.sv */
`timescale 1ns/100ps
`include "mcu_mem_settings.svh"

module renas_memory_tb;
  import mcu_mem_pkg::*;

  // tests take roughly 1000 cycles
  localparam int cycle_limit = 6000;
  localparam logic [2:0] hsize_word = 3'b010;

  logic      clk_l2;
  logic      rst_n;
  logic      imem_hsel;
  logic      dmem_hsel;
  mas_send_t imem_in;
  mas_send_t dmem_in;
  slv_send_t imem_out;
  slv_send_t dmem_out;

  // reference model starts all zero like the sram
  logic [`MEM_DATA_WIDTH-1:0] model [`MEM_WORDS];
  int     errors = 0;
  int     cycles = 0;
  integer seed = 50;

  renas_memory renas_memory_inst (.*);

  bind renas_memory renas_memory_asserts imem_asserts_inst
    (.clk_l2(clk_l2), .rst_n(rst_n), .bus_out(imem_out));
  bind renas_memory renas_memory_asserts dmem_asserts_inst
    (.clk_l2(clk_l2), .rst_n(rst_n), .bus_out(dmem_out));

  initial
  begin
    clk_l2 = 1'b0;
    forever #50 clk_l2 = ~clk_l2;
  end

  always @(posedge clk_l2)
  begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit)
    begin
      $display("timeout: tests did not finish within %0d cycles", cycle_limit);
      $display("Test FAILED");
      $finish;
    end
  end

  // --------------------
  // helpers
  // --------------------
  function automatic logic [31:0] addr_of(input int idx);
    return `MEM_BASE_ADDR + 32'(idx * 4);
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    assert (actual === expected)
    else
    begin
      errors++;
      $display("error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic drive(input bit dport, input bit sel, input mas_send_t bus);
    if (dport)
    begin
      dmem_hsel <= sel;
      dmem_in <= bus;
    end
    else
    begin
      imem_hsel <= sel;
      imem_in <= bus;
    end
  endtask

  // one complete ahb transfer on the port picked by dport
  task automatic transfer(input bit dport, input logic [31:0] addr, input bit write,
                          input logic [2:0] size, input logic [31:0] wdata,
                          output logic [31:0] rdata, output bit resp, output int waits);
    mas_send_t bus;
    slv_send_t rsp;
    bus = '{haddr: addr, htrans: NONSEQ, hwrite: write, hsize: size, hwdata: '0};
    @(posedge clk_l2);
    drive(dport, 1'b1, bus);
    do
      @(negedge clk_l2);
    while (!(dport ? dmem_out.hreadyout : imem_out.hreadyout));
    // data phase starts after this edge
    @(posedge clk_l2);
    bus.htrans = IDLE;
    bus.hwdata = wdata;
    drive(dport, 1'b0, bus);
    waits = 0;
    @(negedge clk_l2);
    rsp = dport ? dmem_out : imem_out;
    while (!rsp.hreadyout)
    begin
      waits++;
      @(negedge clk_l2);
      rsp = dport ? dmem_out : imem_out;
    end
    rdata = rsp.hrdata;
    resp = rsp.hresp;
  endtask

  task automatic write_word(input int idx, input logic [31:0] data);
    logic [31:0] rd;
    bit          resp;
    int          waits;
    transfer(1'b1, addr_of(idx), 1'b1, hsize_word, data, rd, resp, waits);
    check("write wait states", 0, waits);
    check("write hresp", 0, resp);
    model[idx] = data;
  endtask

  task automatic read_word(input bit dport, input int idx, input string name);
    logic [31:0] rd;
    bit          resp;
    int          waits;
    transfer(dport, addr_of(idx), 1'b0, hsize_word, '0, rd, resp, waits);
    check(name, model[idx], rd);
    check({name, " wait states"}, 1, waits);
    check({name, " hresp"}, 0, resp);
  endtask

  task automatic expect_error(input bit dport, input logic [31:0] addr, input bit write,
                              input logic [2:0] size, input string name);
    logic [31:0] rd;
    bit          resp;
    int          waits;
    transfer(dport, addr, write, size, 32'hdead_beef, rd, resp, waits);
    check(name, 1, resp);
    check({name, " wait states"}, 0, waits);
    // gone again in the following cycle
    @(negedge clk_l2);
    check({name, " hresp drop"}, 0, dport ? dmem_out.hresp : imem_out.hresp);
  endtask

  // data port writes with a new address every cycle
  task automatic burst_writes(input int first, input int count);
    mas_send_t bus;
    bus = '{haddr: '0, htrans: NONSEQ, hwrite: 1'b1, hsize: hsize_word, hwdata: '0};
    for (int i = 0; i <= count; i++)
    begin
      @(posedge clk_l2);
      bus.haddr = addr_of(first + i);
      if (i > 0)
      begin
        bus.hwdata = $random(seed);
        model[first + i - 1] = bus.hwdata;
      end
      if (i == count)
        bus.htrans = IDLE;
      drive(1'b1, i < count, bus);
      @(negedge clk_l2);
      check("burst hreadyout", 1, dmem_out.hreadyout);
    end
  endtask

  // --------------------
  // test sequence
  // --------------------
  initial
  begin
    logic [31:0] rd_i;
    logic [31:0] rd_d;
    bit          resp_i;
    bit          resp_d;
    int          waits_i;
    int          waits_d;
    int          idx;
    int          afails;
    rst_n = 1'b0;
    imem_hsel = 1'b0;
    dmem_hsel = 1'b0;
    imem_in = '0;
    dmem_in = '0;
    model = '{default: '0};
    repeat (4) @(posedge clk_l2);
    rst_n <= 1'b1;

    // idle ports then one store and load
    @(negedge clk_l2);
    check("reset imem hreadyout", 1, imem_out.hreadyout);
    check("reset dmem hreadyout", 1, dmem_out.hreadyout);
    check("reset hresp", 0, {imem_out.hresp, dmem_out.hresp});
    write_word(3, 32'hcafe_0003);
    read_word(1'b1, 3, "write then read");

    // fetch what the data port stored at both window edges
    write_word(0, 32'h0000_f00d);
    write_word(`MEM_WORDS - 1, 32'h0bad_ffff);
    write_word(511, 32'h5111_5111);
    read_word(1'b0, 0, "fetch first word");
    read_word(1'b0, `MEM_WORDS - 1, "fetch last word");
    read_word(1'b0, 511, "fetch middle word");

    // error responses leave their target words untouched
    write_word(5, 32'h0000_0005);
    write_word(7, 32'h0000_0007);
    write_word(9, 32'h0000_0009);
    expect_error(1'b0, addr_of(5), 1'b1, hsize_word, "imem write");
    // below base wraps onto the last index and beyond onto index 0
    expect_error(1'b1, `MEM_BASE_ADDR - 4, 1'b1, hsize_word, "below window");
    expect_error(1'b1, addr_of(`MEM_WORDS), 1'b1, hsize_word, "beyond window");
    expect_error(1'b1, addr_of(7) + 2, 1'b1, hsize_word, "misaligned");
    expect_error(1'b1, addr_of(9), 1'b1, 3'b000, "byte size");
    expect_error(1'b0, addr_of(9) + 1, 1'b0, hsize_word, "misaligned fetch");
    read_word(1'b1, 5, "after imem write");
    read_word(1'b1, `MEM_WORDS - 1, "after below window");
    read_word(1'b1, 0, "after beyond window");
    read_word(1'b1, 7, "after misaligned");
    read_word(1'b1, 9, "after byte size");

    // store every cycle then read all back
    burst_writes(100, 16);
    for (int i = 100; i < 116; i++)
      read_word(1'b1, i, "burst readback");

    // fetch and store to one word in the same address phase
    write_word(20, 32'h0000_0020);
    fork
      transfer(1'b0, addr_of(20), 1'b0, hsize_word, '0, rd_i, resp_i, waits_i);
      transfer(1'b1, addr_of(20), 1'b1, hsize_word, 32'h1234_5678, rd_d, resp_d, waits_d);
    join
    check("collision fetch", model[20], rd_i);
    check("collision fetch wait states", 1, waits_i);
    check("collision fetch hresp", 0, resp_i);
    check("collision store wait states", 0, waits_d);
    check("collision store hresp", 0, resp_d);
    model[20] = 32'h1234_5678;
    // fetch address phase one cycle after the store
    fork
      transfer(1'b1, addr_of(21), 1'b1, hsize_word, 32'h8765_4321, rd_d, resp_d, waits_d);
      begin
        @(posedge clk_l2);
        transfer(1'b0, addr_of(21), 1'b0, hsize_word, '0, rd_i, resp_i, waits_i);
      end
    join
    check("fetch after store", 32'h8765_4321, rd_i);
    model[21] = 32'h8765_4321;
    read_word(1'b0, 20, "fetch after collision");

    // random mix of stores, loads and fetches
    repeat (300)
    begin
      idx = $unsigned($random(seed)) % `MEM_WORDS;
      case ($unsigned($random(seed)) % 3)
        0: write_word(idx, $random(seed));
        1: read_word(1'b1, idx, "random load");
        default: read_word(1'b0, idx, "random fetch");
      endcase
    end

    repeat (2) @(posedge clk_l2);
    afails = renas_memory_inst.imem_asserts_inst.fail_count
           + renas_memory_inst.dmem_asserts_inst.fail_count;
    $display("errors: %0d, assertion failures: %0d", errors, afails);
    if (errors == 0 && afails == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

/* bench/renas_memory_asserts.sv */
`timescale 1ns/100ps

module renas_memory_asserts
(
  input logic                   clk_l2,
  input logic                   rst_n,
  input mcu_mem_pkg::slv_send_t bus_out
);

  // number of failed properties on this port
  int fail_count = 0;

  // --------------------
  // ahb response rules
  // --------------------
  // idle outputs while reset is held
  reset_outputs: assert property (@(posedge clk_l2)
    !rst_n |-> bus_out.hreadyout && !bus_out.hresp && (bus_out.hrdata == '0))
  else
  begin
    fail_count++;
    $error("outputs not at their reset values while reset is held");
  end

  // reads have exactly one wait state
  single_wait: assert property (@(posedge clk_l2) disable iff (!rst_n)
    !bus_out.hreadyout |=> bus_out.hreadyout)
  else
  begin
    fail_count++;
    $error("hreadyout low for two cycles in a row");
  end

  // one-cycle error response
  resp_with_ready: assert property (@(posedge clk_l2) disable iff (!rst_n)
    bus_out.hresp |-> bus_out.hreadyout)
  else
  begin
    fail_count++;
    $error("hresp high while hreadyout is low");
  end

  stable_rdata: assert property (@(posedge clk_l2) disable iff (!rst_n)
    !bus_out.hreadyout |-> $stable(bus_out.hrdata))
  else
  begin
    fail_count++;
    $error("hrdata changed during a wait state");
  end

endmodule

/* design/renas_memory.sv */
`timescale 1ns/100ps
`include "mcu_mem_settings.svh"

module renas_memory
(
  // instruction port
  input  logic                   imem_hsel,
  input  mcu_mem_pkg::mas_send_t imem_in,
  output mcu_mem_pkg::slv_send_t imem_out,
  // data port
  input  logic                   dmem_hsel,
  input  mcu_mem_pkg::mas_send_t dmem_in,
  output mcu_mem_pkg::slv_send_t dmem_out,
  // system
  input  logic                   clk_l2,
  input  logic                   rst_n
);
  import mcu_mem_pkg::*;

  mem_req_t                   imem_req;
  mem_req_t                   dmem_req;
  logic                       dmem_wdata_en;
  logic [`MEM_DATA_WIDTH-1:0] imem_rdata;
  logic [`MEM_DATA_WIDTH-1:0] dmem_rdata;

  // --------------------
  // address phase
  // --------------------
  // hreadyout fed back as accept, single slave per port
  ahb_addr_stage #(.write_allowed(1'b0)) imem_addr_inst (
    .clk_l2   (clk_l2),
    .rst_n    (rst_n),
    .hsel     (imem_hsel),
    .bus_in   (imem_in),
    .accept   (imem_out.hreadyout),
    .req      (imem_req),
    .wdata_en ()
  );

  ahb_addr_stage #(.write_allowed(1'b1)) dmem_addr_inst (
    .clk_l2   (clk_l2),
    .rst_n    (rst_n),
    .hsel     (dmem_hsel),
    .bus_in   (dmem_in),
    .accept   (dmem_out.hreadyout),
    .req      (dmem_req),
    .wdata_en (dmem_wdata_en)
  );

  // --------------------
  // word array
  // --------------------
  // port a for fetch, port b for load / store
  dual_port_sram #(.depth(`MEM_WORDS), .width(`MEM_DATA_WIDTH)) sram_inst (
    .clk_l2  (clk_l2),
    .addr_a  (imem_req.word_index),
    .rdata_a (imem_rdata),
    .addr_b  (dmem_req.word_index),
    .wen_b   (dmem_wdata_en),
    .wdata_b (dmem_in.hwdata),
    .rdata_b (dmem_rdata)
  );

  // --------------------
  // response phase
  // --------------------
  ahb_resp_stage imem_resp_inst (
    .clk_l2  (clk_l2),
    .rst_n   (rst_n),
    .req     (imem_req),
    .rdata   (imem_rdata),
    .bus_out (imem_out)
  );

  ahb_resp_stage dmem_resp_inst (
    .clk_l2  (clk_l2),
    .rst_n   (rst_n),
    .req     (dmem_req),
    .rdata   (dmem_rdata),
    .bus_out (dmem_out)
  );

endmodule

/* design/ahb_resp_stage.sv */
`timescale 1ns/100ps
`include "mcu_mem_settings.svh"

module ahb_resp_stage
(
  input  logic                       clk_l2,
  input  logic                       rst_n,
  input  mcu_mem_pkg::mem_req_t      req,
  input  logic [`MEM_DATA_WIDTH-1:0] rdata,
  output mcu_mem_pkg::slv_send_t     bus_out
);
  import mcu_mem_pkg::*;

  resp_state_e                state;
  resp_state_e                state_next;
  logic [`MEM_DATA_WIDTH-1:0] rdata_hold;
  logic                       read_pending;

  // fresh read, sram has not produced data yet
  assign read_pending = (state == RESP_IDLE) && (req.op == OP_READ);

  // --------------------
  // fsm
  // --------------------
  always_comb
  begin
    case (state)
      RESP_IDLE:
        state_next = read_pending ? RESP_WAIT : RESP_IDLE;
      // one wait state only
      RESP_WAIT:
        state_next = RESP_IDLE;
      default:
        state_next = RESP_IDLE;
    endcase
  end

  always_ff @(posedge clk_l2, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= RESP_IDLE;
      rdata_hold <= '0;
    end
    else
    begin
      state <= state_next;
      // keep the word after the sram moves on
      if (state == RESP_WAIT)
        rdata_hold <= rdata;
    end
  end

  // --------------------
  // bus outputs
  // --------------------
  always_comb
  begin
    bus_out.hreadyout = !read_pending;
    // single-cycle error, hreadyout stays high
    bus_out.hresp = (req.op == OP_ERROR);
    // sram data goes straight out in the wait-done cycle
    bus_out.hrdata = (state == RESP_WAIT) ? rdata : rdata_hold;
  end

endmodule

/* design/dual_port_sram.sv */
`timescale 1ns/100ps
`include "mcu_mem_settings.svh"

module dual_port_sram
#(
  parameter int depth = `MEM_WORDS,
  parameter int width = `MEM_DATA_WIDTH
)
(
  input  logic                     clk_l2,
  // port a, read only
  input  logic [$clog2(depth)-1:0] addr_a,
  output logic [width-1:0]         rdata_a,
  // port b, read / write
  input  logic [$clog2(depth)-1:0] addr_b,
  input  logic                     wen_b,
  input  logic [width-1:0]         wdata_b,
  output logic [width-1:0]         rdata_b
);

  logic [width-1:0] mem [depth];

  // start from a known all-zero array
  initial
  begin
    for (int i = 0; i < depth; i++)
      mem[i] = '0;
  end

  // --------------------
  // synchronous access
  // --------------------
  // nonblocking reads see the old word, so both ports are read-first
  always_ff @(posedge clk_l2)
  begin
    rdata_a <= mem[addr_a];
    rdata_b <= mem[addr_b];
    if (wen_b)
      mem[addr_b] <= wdata_b;
  end

endmodule

/* design/ahb_addr_stage.sv */
`timescale 1ns/100ps
`include "mcu_mem_settings.svh"

module ahb_addr_stage
#(
  parameter bit write_allowed = 1'b1
)
(
  input  logic                   clk_l2,
  input  logic                   rst_n,
  input  logic                   hsel,
  input  mcu_mem_pkg::mas_send_t bus_in,
  input  logic                   accept,
  output mcu_mem_pkg::mem_req_t  req,
  output logic                   wdata_en
);
  import mcu_mem_pkg::*;

  localparam int idx_w = $clog2(`MEM_WORDS);
  // window size in bytes
  localparam logic [`MEM_ADDR_WIDTH-1:0] win_bytes = `MEM_WORDS * 4;
  // hsize code for 32-bit transfers
  localparam logic [2:0] hsize_word = 3'b010;

  logic                       valid_htrans;
  logic                       accepted;
  logic [`MEM_ADDR_WIDTH-1:0] offset;
  logic                       in_window;
  logic                       aligned;
  logic                       word_size;
  mem_op_e                    next_op;

  // --------------------
  // classify the address phase
  // --------------------
  // seq handled like nonseq while idle and busy are ignored
  assign valid_htrans = (bus_in.htrans == NONSEQ) || (bus_in.htrans == SEQ);
  // accept only when our own data phase is done
  assign accepted = hsel && valid_htrans && accept;

  // byte offset inside the window
  assign offset = bus_in.haddr - `MEM_BASE_ADDR;
  // below base wraps to a huge offset and fails the same compare
  assign in_window = (offset < win_bytes);
  assign aligned = (bus_in.haddr[1:0] == 2'b00);
  assign word_size = (bus_in.hsize == hsize_word);

  always_comb
  begin
    if (!in_window || !aligned || !word_size)
      next_op = OP_ERROR;
    // instruction port is read only
    else if (bus_in.hwrite && !write_allowed)
      next_op = OP_ERROR;
    else if (bus_in.hwrite)
      next_op = OP_WRITE;
    else
      next_op = OP_READ;
  end

  // --------------------
  // request register
  // --------------------
  always_ff @(posedge clk_l2, negedge rst_n)
  begin
    if (!rst_n)
      req <= '0;
    else if (accepted)
    begin
      req.op <= next_op;
      req.word_index <= offset[idx_w+1:2];
    end
    // accept low holds a read through its wait state
    else if (accept)
      req.op <= OP_NONE;
  end

  // write data phase is the cycle right after acceptance
  assign wdata_en = (req.op == OP_WRITE);

endmodule

/* design/mcu_mem_pkg.sv */
`include "mcu_mem_settings.svh"

package mcu_mem_pkg;

  // --------------------
  // enums
  // --------------------
  // ahb transfer type, encoding from the spec
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // operation held by a port between address and data phase
  typedef enum logic [1:0] {
    OP_NONE  = 2'b00,
    OP_READ  = 2'b01,
    OP_WRITE = 2'b10,
    OP_ERROR = 2'b11
  } mem_op_e;

  // response stage fsm
  typedef enum logic {
    RESP_IDLE = 1'b0,
    RESP_WAIT = 1'b1
  } resp_state_e;

  // --------------------
  // bundles
  // --------------------
  // master to slave
  typedef struct packed {
    logic [`MEM_ADDR_WIDTH-1:0] haddr;
    htrans_e                    htrans;
    logic                       hwrite;
    logic [2:0]                 hsize;
    logic [`MEM_DATA_WIDTH-1:0] hwdata;
  } mas_send_t;

  // slave to master
  typedef struct packed {
    logic [`MEM_DATA_WIDTH-1:0] hrdata;
    logic                       hreadyout;
    logic                       hresp;
  } slv_send_t;

  // registered address phase, base already removed
  typedef struct packed {
    mem_op_e                        op;
    logic [$clog2(`MEM_WORDS)-1:0]  word_index;
  } mem_req_t;

endpackage

/* include/mcu_mem_settings.svh */
`ifndef MCU_MEM_SETTINGS_SVH
`define MCU_MEM_SETTINGS_SVH

// --------------------
// bus widths
// --------------------
// word width, same as hrdata / hwdata
`define MEM_DATA_WIDTH 32
// haddr width
`define MEM_ADDR_WIDTH 32

// --------------------
// memory window
// --------------------
// first byte address seen by both ports
`define MEM_BASE_ADDR 32'h0000_0400
// depth in 32-bit words, index width comes from clog2
`define MEM_WORDS 1024

`endif
